//--- compile.f
src/arp_pkg.sv
src/arp_mac_if.sv
src/arp_req_dispatch.sv
src/arp_tx.sv
src/arp_mac_arb.sv
src/arp_tx_top.sv
dv/arp_tx_tb.sv

//--- Bender.yml
package:
  name: arp_tx

sources:
  - files:
      - src/arp_pkg.sv
      - src/arp_mac_if.sv
      - src/arp_req_dispatch.sv
      - src/arp_tx.sv
      - src/arp_mac_arb.sv
      - src/arp_tx_top.sv
  - target: test
    files:
      - dv/arp_tx_tb.sv

//--- dv/arp_tx_tb.sv
`timescale 1ns/1ps

module arp_tx_tb;
  import arp_pkg::*;

  typedef logic [95:0]                req_rec_t; // {oper, dst_mac, dst_ip}
  typedef logic [ARP_FRAME_LEN*8-1:0] frame_t;   // First byte in the top bits.

  localparam int N_REQ   = 49;
  localparam int WD_TIME = N_REQ * (N_CHAN + 1) * 50 * 40;

  logic       clk = 1'b0;
  logic       fsm_rst;
  logic       req_valid;
  chan_idx_t  req_chan;
  arp_oper_t  req_oper;
  mac_addr_t  req_dst_mac;
  ipv4_addr_t req_dst_ip;
  mac_addr_t  dev_mac [N_CHAN];
  ipv4_addr_t dev_ip [N_CHAN];
  logic       req_drop;
  chan_vec_t  chan_busy;
  byte_t      tx_dat;
  logic       tx_val;
  logic       tx_sof;
  logic       tx_eof;
  chan_idx_t  tx_chan;
  mac_addr_t  tx_dst_mac;
  mac_addr_t  tx_src_mac;

  req_rec_t  exp_q [N_CHAN][$]; // Accepted requests per channel.
  int        pending [N_CHAN];  // Frames not yet finished per channel.
  int        served [N_CHAN];
  int        drops_exp, drops_seen;
  int        checks, mismatches, failures;
  logic      drop_due;
  logic      frame_open;
  logic      frame_known;
  int        byte_idx;
  chan_idx_t cur_chan;
  frame_t    exp_frame;
  mac_addr_t exp_dst;
  integer    seed = 77044;

  always #20 clk = ~clk;

  arp_tx_top u_dut (
    .clk (clk), .fsm_rst (fsm_rst), .req_valid (req_valid), .req_chan (req_chan),
    .req_oper (req_oper), .req_dst_mac (req_dst_mac), .req_dst_ip (req_dst_ip),
    .dev_mac (dev_mac), .dev_ip (dev_ip), .req_drop (req_drop), .chan_busy (chan_busy),
    .tx_dat (tx_dat), .tx_val (tx_val), .tx_sof (tx_sof), .tx_eof (tx_eof),
    .tx_chan (tx_chan), .tx_dst_mac (tx_dst_mac), .tx_src_mac (tx_src_mac)
  );

  // ARP body for Ethernet and IPv4, zero padded to the minimum frame.
  function automatic frame_t arp_frame(arp_oper_t op, mac_addr_t sha, ipv4_addr_t spa,
                                       mac_addr_t tha, ipv4_addr_t tpa);
    return {16'h0001, 16'h0800, 8'h06, 8'h04, op, sha, spa, tha, tpa, 144'h0};
  endfunction

  task automatic check_byte(string name, byte_t got, byte_t exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_mac(string name, mac_addr_t got, mac_addr_t exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_chan(string name, chan_idx_t got, chan_idx_t exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_fail(string what);
    failures++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  // Takes one output byte and compares it with the frame expected for its channel.
  task automatic collect_byte();
    req_rec_t rec;
    if (!tx_val) begin
      if (frame_open) begin
        report_fail($sformatf("frame on channel %0d broke off after %0d bytes",
                              cur_chan, byte_idx));
        frame_open = 1'b0;
      end
      return;
    end
    if (tx_sof) begin
      if (frame_open) report_fail("a new frame started before the open one ended");
      frame_open  = 1'b1;
      byte_idx    = 0;
      cur_chan    = tx_chan;
      frame_known = (exp_q[tx_chan].size() != 0);
      if (frame_known) begin
        rec       = exp_q[tx_chan].pop_front();
        exp_dst   = rec[79:32];
        exp_frame = arp_frame(rec[95:80], dev_mac[cur_chan], dev_ip[cur_chan],
                              rec[79:32], rec[31:0]);
      end else begin
        report_fail($sformatf("unexpected frame on channel %0d", tx_chan));
      end
    end else if (!frame_open) begin
      report_fail("a byte arrived outside any frame");
      return;
    end
    check_chan("tx_chan", tx_chan, cur_chan);
    check_flag("tx_eof", tx_eof, byte_idx == ARP_FRAME_LEN - 1);
    if (frame_known) begin
      check_byte($sformatf("tx_dat[%0d]", byte_idx), tx_dat,
                 exp_frame[(ARP_FRAME_LEN - 1 - byte_idx) * 8 +: 8]);
      check_mac("tx_dst_mac", tx_dst_mac, exp_dst);
      check_mac("tx_src_mac", tx_src_mac, dev_mac[cur_chan]);
    end
    byte_idx++;
    if (tx_eof || byte_idx == ARP_FRAME_LEN) begin
      frame_open = 1'b0;
      served[cur_chan]++;
      if (pending[cur_chan] != 0) pending[cur_chan]--;
    end
  endtask

  // A finished frame frees its channel before the request of the same edge is judged.
  always @(posedge clk) begin
    if (fsm_rst) begin
      drop_due   = 1'b0;
      frame_open = 1'b0;
    end else begin
      check_flag("req_drop", req_drop, drop_due);
      if (req_drop) drops_seen++;
      collect_byte();
      drop_due = 1'b0;
      if (req_valid) begin
        if (pending[req_chan] != 0) begin
          drop_due = 1'b1;
          drops_exp++;
        end else begin
          exp_q[req_chan].push_back({req_oper, req_dst_mac, req_dst_ip});
          pending[req_chan]++;
        end
      end
    end
  end

  task automatic send_request(chan_idx_t ch, arp_oper_t op, mac_addr_t mac, ipv4_addr_t ip);
    req_valid   = 1'b1;
    req_chan    = ch;
    req_oper    = op;
    req_dst_mac = mac;
    req_dst_ip  = ip;
    @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (pending.sum() != 0) begin
      @(posedge clk);
      #2;
    end
    repeat (3) @(posedge clk);
    #2;
  endtask

  task automatic check_served(int ch, int exp);
    if (served[ch] != exp) begin
      report_fail($sformatf("channel %0d sent %0d frames instead of %0d", ch, served[ch], exp));
    end
  endtask

  initial begin
    int        served_before [N_CHAN];
    int        drops_before;
    int        gap;
    arp_oper_t op;
    fsm_rst     = 1'b1;
    req_valid   = 1'b0;
    req_chan    = '0;
    req_oper    = '0;
    req_dst_mac = '0;
    req_dst_ip  = '0;
    for (int i = 0; i < N_CHAN; i++) begin
      dev_mac[i] = 48'h02_00_5e_00_10_00 + mac_addr_t'(i * 17);
      dev_ip[i]  = 32'hc0a8_0a01 + ipv4_addr_t'(i);
    end
    repeat (5) @(posedge clk);
    #2;
    fsm_rst = 1'b0;
    check_flag("tx_val", tx_val, 1'b0);
    check_flag("tx_sof", tx_sof, 1'b0);
    check_flag("tx_eof", tx_eof, 1'b0);
    check_flag("req_drop", req_drop, 1'b0);
    for (int i = 0; i < N_CHAN; i++) check_flag($sformatf("chan_busy[%0d]", i), chan_busy[i], 1'b0);

    send_request(1, 16'd1, 48'h0, 32'hc0a8_0a64); // Who-has.
    wait_idle();
    check_served(1, 1);
    send_request(3, 16'd2, 48'h0a1b_2c3d_4e5f, 32'hc0a8_0a20); // Reply.
    wait_idle();
    check_served(3, 1);

    served_before = served;
    for (int i = 0; i < N_CHAN; i++) begin
      send_request(chan_idx_t'(i), 16'd1, 48'h0016_3e00_0000 + mac_addr_t'(i),
                   32'h0a00_0001 + ipv4_addr_t'(i));
    end
    wait_idle();
    for (int i = 0; i < N_CHAN; i++) check_served(i, served_before[i] + 1);

    // The second request hits the send in flight, the third a busy channel.
    served_before = served;
    drops_before  = drops_seen;
    send_request(2, 16'd1, 48'h0016_3e00_00aa, 32'h0a00_00aa);
    send_request(2, 16'd2, 48'h0016_3e00_00bb, 32'h0a00_00bb);
    repeat (10) @(posedge clk);
    #2;
    send_request(2, 16'd1, 48'h0016_3e00_00cc, 32'h0a00_00cc);
    wait_idle();
    check_served(2, served_before[2] + 1);
    if (drops_seen - drops_before != 2) report_fail("busy channel requests were not all dropped");

    for (int n = 0; n < 40; n++) begin
      op  = (($random(seed) & 1) != 0) ? 16'd2 : 16'd1;
      gap = $random(seed) & 15;
      send_request(chan_idx_t'($random(seed)), op,
                   mac_addr_t'({$random(seed), $random(seed)}), ipv4_addr_t'($random(seed)));
      repeat (gap) @(posedge clk);
      #2;
    end
    wait_idle();
    if (drops_seen != drops_exp) begin
      mismatches++;
      $display("MISMATCH drop_count: got %h expected %h", drops_seen, drops_exp);
    end
    for (int i = 0; i < N_CHAN; i++) begin
      if (exp_q[i].size() != 0) report_fail($sformatf("frames missing on channel %0d", i));
    end

    $display("Checks: %0d  mismatches: %0d  other errors: %0d", checks, mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WD_TIME);
    $display("ERROR: the run did not finish within %0d ns", WD_TIME);
    $display("Checks: %0d  mismatches: %0d  other errors: %0d", checks, mismatches,
             failures + 1);
    $display("Errors found");
    $finish;
  end

endmodule : arp_tx_tb

//--- src/arp_tx_top.sv
`timescale 1ns/1ps

module arp_tx_top (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                req_valid,
  input  arp_pkg::chan_idx_t  req_chan,
  input  arp_pkg::arp_oper_t  req_oper,
  input  arp_pkg::mac_addr_t  req_dst_mac,
  input  arp_pkg::ipv4_addr_t req_dst_ip,
  input  arp_pkg::mac_addr_t  dev_mac [arp_pkg::N_CHAN],
  input  arp_pkg::ipv4_addr_t dev_ip [arp_pkg::N_CHAN],
  output logic                req_drop,
  output arp_pkg::chan_vec_t  chan_busy,
  output arp_pkg::byte_t      tx_dat,
  output logic                tx_val,
  output logic                tx_sof,
  output logic                tx_eof,
  output arp_pkg::chan_idx_t  tx_chan,
  output arp_pkg::mac_addr_t  tx_dst_mac,
  output arp_pkg::mac_addr_t  tx_src_mac
);
  import arp_pkg::*;

  chan_vec_t  send;
  arp_oper_t  oper;
  mac_addr_t  dst_mac;
  ipv4_addr_t dst_ip;

  arp_mac_if mac_if [N_CHAN] ();

  arp_req_dispatch u_dispatch (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .req_valid   (req_valid),
    .req_chan    (req_chan),
    .req_oper    (req_oper),
    .req_dst_mac (req_dst_mac),
    .req_dst_ip  (req_dst_ip),
    .chan_busy   (chan_busy),
    .send        (send),
    .oper        (oper),
    .dst_mac     (dst_mac),
    .dst_ip      (dst_ip),
    .req_drop    (req_drop)
  );

  // One channel per local device address.
  for (genvar i = 0; i < N_CHAN; i++) begin : g_tx
    arp_tx u_tx (
      .clk     (clk),
      .fsm_rst (fsm_rst),
      .dev_mac (dev_mac[i]),
      .dev_ip  (dev_ip[i]),
      .send    (send[i]),
      .oper    (oper),
      .dst_mac (dst_mac),
      .dst_ip  (dst_ip),
      .mac     (mac_if[i]),
      .busy    (chan_busy[i])
    );
  end

  arp_mac_arb u_arb (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .chan       (mac_if),
    .tx_dat     (tx_dat),
    .tx_val     (tx_val),
    .tx_sof     (tx_sof),
    .tx_eof     (tx_eof),
    .tx_chan    (tx_chan),
    .tx_dst_mac (tx_dst_mac),
    .tx_src_mac (tx_src_mac)
  );

endmodule : arp_tx_top

//--- src/arp_mac_arb.sv
`timescale 1ns/1ps

module arp_mac_arb (
  input  logic               clk,
  input  logic               fsm_rst,
  arp_mac_if.arb             chan [arp_pkg::N_CHAN],
  output arp_pkg::byte_t     tx_dat,
  output logic               tx_val,
  output logic               tx_sof,
  output logic               tx_eof,
  output arp_pkg::chan_idx_t tx_chan,
  output arp_pkg::mac_addr_t tx_dst_mac,
  output arp_pkg::mac_addr_t tx_src_mac
);
  import arp_pkg::*;

  chan_vec_t rdy_vec;
  chan_vec_t val_vec;
  chan_vec_t sof_vec;
  chan_vec_t eof_vec;
  byte_t     dat_arr [N_CHAN];
  mac_addr_t dst_arr [N_CHAN];
  mac_addr_t src_arr [N_CHAN];

  chan_vec_t req_q;
  logic      lock_q;
  chan_idx_t gnt_q;   // Current grant, and the last one while unlocked.
  chan_idx_t sel;
  chan_idx_t cand;
  logic      found;
  logic      frame_open;

  // Interface arrays cannot take a variable index, so flatten them here.
  for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
    assign rdy_vec[i]    = chan[i].rdy;
    assign val_vec[i]    = chan[i].val;
    assign sof_vec[i]    = chan[i].sof;
    assign eof_vec[i]    = chan[i].eof;
    assign dat_arr[i]    = chan[i].dat;
    assign dst_arr[i]    = chan[i].dst_mac;
    assign src_arr[i]    = chan[i].src_mac;
    assign chan[i].req   = req_q[i];
  end

  // Search starts one past the last grant and wraps around.
  always_comb begin
    sel   = gnt_q;
    cand  = gnt_q;
    found = 1'b0;
    for (int k = 1; k <= N_CHAN; k++) begin
      cand = gnt_q + chan_idx_t'(k);
      if (!found && rdy_vec[cand]) begin
        sel   = cand;
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      lock_q <= 1'b0;
      gnt_q  <= chan_idx_t'(N_CHAN - 1); // So channel 0 wins first.
      req_q  <= '0;
    end else begin
      req_q <= '0;
      if (!lock_q) begin
        if (found) begin
          lock_q <= 1'b1;
          gnt_q  <= sel;
          req_q  <= chan_vec_t'(1) << sel;
        end
      end else if (eof_vec[gnt_q]) begin
        lock_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx_val <= 1'b0;
      tx_sof <= 1'b0;
      tx_eof <= 1'b0;
    end else begin
      tx_val <= lock_q & val_vec[gnt_q];
      tx_sof <= lock_q & sof_vec[gnt_q];
      tx_eof <= lock_q & eof_vec[gnt_q];
    end
  end

  always_ff @(posedge clk) begin
    tx_dat     <= dat_arr[gnt_q];
    tx_chan    <= gnt_q;
    tx_dst_mac <= dst_arr[gnt_q];
    tx_src_mac <= src_arr[gnt_q];
  end

  // Tracks the output stream between sof and eof.
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      frame_open <= 1'b0;
    end else if (tx_val && tx_eof) begin
      frame_open <= 1'b0;
    end else if (tx_val && tx_sof) begin
      frame_open <= 1'b1;
    end
  end

  grant_onehot_a: assert property (@(posedge clk) disable iff (fsm_rst)
    $onehot0(req_q));

  sof_closed_a: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_sof |-> !frame_open);

  // A granted channel streams without gaps.
  no_gap_a: assert property (@(posedge clk) disable iff (fsm_rst)
    frame_open |-> tx_val);

endmodule : arp_mac_arb

//--- src/arp_tx.sv
`timescale 1ns/1ps

module arp_tx (
  input  logic                clk,
  input  logic                fsm_rst,
  input  arp_pkg::mac_addr_t  dev_mac,
  input  arp_pkg::ipv4_addr_t dev_ip,
  input  logic                send,
  input  arp_pkg::arp_oper_t  oper,
  input  arp_pkg::mac_addr_t  dst_mac,
  input  arp_pkg::ipv4_addr_t dst_ip,
  arp_mac_if.tx               mac,
  output logic                busy
);
  import arp_pkg::*;

  // Done is raised on the edge that leaves the counter on the last byte.
  localparam logic [ARP_CNT_W-1:0] LAST_CNT = ARP_CNT_W'(ARP_FRAME_LEN - 2);

  arp_tx_fsm_t             fsm;
  byte_t [ARP_HDR_LEN-1:0] data;
  logic [ARP_CNT_W-1:0]    byte_cnt;
  logic                    done;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      fsm      <= arp_idle_s;
      busy     <= 1'b0;
      done     <= 1'b0;
      byte_cnt <= '0;
      mac.rdy  <= 1'b0;
      mac.val  <= 1'b0;
      mac.sof  <= 1'b0;
    end else begin
      case (fsm)
        arp_idle_s: begin
          if (send) begin
            fsm  <= arp_wait_s;
            busy <= 1'b1;
          end
        end
        arp_wait_s: begin
          mac.rdy <= !mac.req; // Rdy drops once the grant arrives.
          if (mac.req) begin
            fsm <= arp_delay_s;
          end
        end
        arp_delay_s: begin
          fsm      <= arp_tx_s;
          mac.val  <= 1'b1;
          mac.sof  <= 1'b1;
          byte_cnt <= '0;
        end
        arp_tx_s: begin
          mac.sof  <= 1'b0;
          byte_cnt <= byte_cnt + 1'b1;
          done     <= (byte_cnt == LAST_CNT);
          if (done) begin
            fsm     <= arp_idle_s;
            busy    <= 1'b0;
            mac.val <= 1'b0;
          end
        end
        default: fsm <= arp_idle_s;
      endcase
    end
  end

  // Payload is loaded once per request. Zeros follow it out as padding.
  always_ff @(posedge clk) begin
    if (fsm == arp_idle_s && send) begin
      data <= {ARP_HW_TYPE, ARP_PROTO_IPV4, ARP_HW_LEN, ARP_PROTO_LEN, oper,
               dev_mac, dev_ip, dst_mac, dst_ip};
      mac.dst_mac <= dst_mac;
      mac.src_mac <= dev_mac;
    end else if (fsm == arp_tx_s) begin
      data <= {data[ARP_HDR_LEN-2:0], byte_t'(0)};
    end
  end

  assign mac.dat = data[ARP_HDR_LEN-1];
  assign mac.eof = done;

  sof_val_a: assert property (@(posedge clk) disable iff (fsm_rst)
    mac.sof |-> mac.val);

  // The arbiter may only grant a channel that is waiting for it.
  req_wait_a: assert property (@(posedge clk) disable iff (fsm_rst)
    mac.req |-> (fsm == arp_wait_s));

endmodule : arp_tx

//--- src/arp_req_dispatch.sv
`timescale 1ns/1ps

module arp_req_dispatch (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                req_valid,
  input  arp_pkg::chan_idx_t  req_chan,
  input  arp_pkg::arp_oper_t  req_oper,
  input  arp_pkg::mac_addr_t  req_dst_mac,
  input  arp_pkg::ipv4_addr_t req_dst_ip,
  input  arp_pkg::chan_vec_t  chan_busy,
  output arp_pkg::chan_vec_t  send,
  output arp_pkg::arp_oper_t  oper,
  output arp_pkg::mac_addr_t  dst_mac,
  output arp_pkg::ipv4_addr_t dst_ip,
  output logic                req_drop
);
  import arp_pkg::*;

  chan_vec_t busy_eff;
  chan_vec_t sel;

  // A channel raises busy one cycle after its send pulse.
  // The pulse in flight counts as busy so a back-to-back request is dropped.
  assign busy_eff = chan_busy | send;
  assign sel      = chan_vec_t'(1) << req_chan;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      send     <= '0;
      req_drop <= 1'b0;
    end else begin
      send     <= '0;
      req_drop <= 1'b0;
      if (req_valid) begin
        if (busy_eff[req_chan]) begin
          req_drop <= 1'b1;
        end else begin
          send <= sel;
        end
      end
    end
  end

  // The fields sit on the shared buses alongside the send pulse.
  always_ff @(posedge clk) begin
    if (req_valid) begin
      oper    <= req_oper;
      dst_mac <= req_dst_mac;
      dst_ip  <= req_dst_ip;
    end
  end

  send_onehot_a: assert property (@(posedge clk) disable iff (fsm_rst)
    $onehot0(send));

endmodule : arp_req_dispatch

//--- src/arp_mac_if.sv
`timescale 1ns/1ps

interface arp_mac_if;
  import arp_pkg::*;

  logic      rdy;     // Channel has a frame waiting.
  logic      req;     // One-cycle grant from the arbiter.
  mac_addr_t dst_mac;
  mac_addr_t src_mac;
  byte_t     dat;
  logic      val;
  logic      sof;
  logic      eof;

  modport tx (
    output rdy, dst_mac, src_mac, dat, val, sof, eof,
    input  req
  );

  modport arb (
    input  rdy, dst_mac, src_mac, dat, val, sof, eof,
    output req
  );

endinterface : arp_mac_if

//--- src/arp_pkg.sv
package arp_pkg;

  localparam int N_CHAN = 4;

  // Frame geometry for Ethernet hardware and IPv4 protocol addresses.
  localparam int ARP_HDR_LEN   = 28;
  localparam int ARP_FRAME_LEN = 46; // Minimum Ethernet body, zero padded.
  localparam int ARP_CNT_W     = $clog2(ARP_FRAME_LEN);

  // Fixed header fields.
  localparam logic [15:0] ARP_HW_TYPE    = 16'd1;
  localparam logic [15:0] ARP_PROTO_IPV4 = 16'h0800;
  localparam logic [7:0]  ARP_HW_LEN     = 8'd6;
  localparam logic [7:0]  ARP_PROTO_LEN  = 8'd4;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] arp_oper_t; // 1 is who-has, 2 is a reply.
  typedef logic [7:0]  byte_t;

  typedef logic [$clog2(N_CHAN)-1:0] chan_idx_t;
  typedef logic [N_CHAN-1:0]         chan_vec_t;

  // Channel sequencing.
  typedef enum logic [1:0] {
    arp_idle_s,
    arp_wait_s,
    arp_delay_s,
    arp_tx_s
  } arp_tx_fsm_t;

endpackage : arp_pkg
